// ==== build.f ====
source/adc_types_pkg.sv
source/adc_regs_pkg.sv
source/adc_deserializer.sv
source/adc_record_ctrl.sv
source/adc_sample_fifo.sv
source/adc_apb_regs.sv
source/adc_rx_top.sv
verification/adc_rx_checker.sv
verification/adc_rx_tb.sv

// ==== source/adc_apb_regs.sv ====
`timescale 1ns/1ps

module adc_apb_regs (
    input  logic                        ADC_CLK,
    input  logic                        RST,
    input  adc_regs_pkg::apb_req_t      apb,
    output adc_regs_pkg::apb_data_t     prdata,
    output logic                        soft_rst,
    output logic                        start,
    output adc_types_pkg::rec_count_t   rec_count,
    input  logic                        busy,
    input  logic                        empty,
    input  logic                        full,
    input  logic                        overflow,
    input  adc_types_pkg::record_word_t head,
    output logic                        pop
);

    localparam int count_bits = $bits(adc_types_pkg::rec_count_t);

    logic                    access;
    logic                    wr_access;
    logic                    rd_access;
    logic                    ctrl_wr;
    adc_regs_pkg::apb_data_t status_word;

    assign access    = apb.psel && apb.penable;
    assign wr_access = access && apb.pwrite;
    assign rd_access = access && !apb.pwrite;
    assign ctrl_wr   = wr_access && (apb.paddr == adc_regs_pkg::ctrl_addr);

    always_ff @(posedge ADC_CLK) begin
        if (RST) begin
            rec_count <= adc_types_pkg::rec_count_t'(1);
            soft_rst  <= 1'b0;
            start     <= 1'b0;
        end else begin
            // one cycle pulses
            soft_rst <= ctrl_wr && apb.pwdata[adc_regs_pkg::soft_rst_bit];
            start    <= ctrl_wr && apb.pwdata[adc_regs_pkg::start_bit];
            if (wr_access && (apb.paddr == adc_regs_pkg::count_addr)) begin
                rec_count <= apb.pwdata[count_bits-1:0];
            end
        end
    end

    always_comb begin
        status_word = '0;
        status_word[adc_regs_pkg::busy_bit]     = busy;
        status_word[adc_regs_pkg::empty_bit]    = empty;
        status_word[adc_regs_pkg::full_bit]     = full;
        status_word[adc_regs_pkg::overflow_bit] = overflow;
    end

    always_comb begin
        prdata = '0;
        if (rd_access) begin
            case (apb.paddr)
                adc_regs_pkg::ctrl_addr:   prdata = '0; // pulses only
                adc_regs_pkg::count_addr:  prdata = 32'(rec_count);
                adc_regs_pkg::status_addr: prdata = status_word;
                adc_regs_pkg::data_addr: begin
                    if (!empty) begin
                        prdata = head;
                    end
                end
                default:                   prdata = '0;
            endcase
        end
    end

    // fifo advances on the edge that ends the access phase
    assign pop = rd_access && (apb.paddr == adc_regs_pkg::data_addr) && !empty;

endmodule

// ==== source/adc_deserializer.sv ====
`timescale 1ns/1ps

module adc_deserializer (
    input  logic                   ADC_CLK,
    input  logic                   RST,
    input  logic                   adc_in,
    input  logic                   adc_fco,
    output adc_types_pkg::sample_t sample,
    output logic                   sample_valid
);

    localparam int unsigned num_bits = $bits(adc_types_pkg::sample_t);
    localparam logic [3:0]  last_bit = 4'(num_bits - 1);
    localparam logic [3:0]  cnt_idle = 4'(num_bits); // parked, no frame seen

    logic                   lane_q;
    logic [1:0]             fco_sync;
    logic                   fco_rise;
    logic [3:0]             bit_cnt;
    adc_types_pkg::sample_t shreg;

    // lane and fco both see one register before use
    always_ff @(posedge ADC_CLK) begin
        lane_q <= adc_in;
        shreg  <= {shreg[num_bits-2:0], lane_q}; // msb arrives first
    end

    always_ff @(posedge ADC_CLK) begin
        if (RST) begin
            fco_sync <= '0;
        end else begin
            fco_sync <= {fco_sync[0], adc_fco};
        end
    end

    assign fco_rise = fco_sync[0] & ~fco_sync[1];

    always_ff @(posedge ADC_CLK) begin
        if (RST) begin
            bit_cnt      <= cnt_idle;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= (bit_cnt == last_bit);
            if (fco_rise) begin
                bit_cnt <= '0;
            end else if (bit_cnt != cnt_idle) begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // shreg holds the full frame while the counter sits on the last bit
    always_ff @(posedge ADC_CLK) begin
        if (bit_cnt == last_bit) begin
            sample <= shreg;
        end
    end

endmodule

// ==== source/adc_record_ctrl.sv ====
`timescale 1ns/1ps

module adc_record_ctrl (
    input  logic                        ADC_CLK,
    input  logic                        RST,
    input  logic                        soft_rst,
    input  logic                        start,
    input  adc_types_pkg::rec_count_t   rec_count,
    input  adc_types_pkg::sample_t      sample,
    input  logic                        sample_valid,
    input  logic                        adc_sync,
    output adc_types_pkg::record_word_t rec_word,
    output logic                        rec_write,
    output logic                        busy
);

    // lane reg, shift reg and sample reg in the deserializer
    localparam int sync_delay = 3;

    logic [sync_delay-1:0]     sync_pipe;
    adc_types_pkg::rec_state_t state;
    adc_types_pkg::rec_count_t kept;
    logic                      last_word;

    // lines the sync level up with the frame that produced the sample
    always_ff @(posedge ADC_CLK) begin
        sync_pipe <= {sync_pipe[sync_delay-2:0], adc_sync};
    end

    assign busy      = (state == adc_types_pkg::recording);
    assign rec_write = busy && sample_valid;
    assign last_word = (rec_count != '0) && ((kept + 24'd1) == rec_count);

    always_ff @(posedge ADC_CLK) begin
        if (RST || soft_rst) begin
            state <= adc_types_pkg::idle;
            kept  <= '0;
        end else if (start) begin
            state <= adc_types_pkg::recording;
            kept  <= '0;
        end else if (rec_write) begin
            kept <= kept + 24'd1; // wraps harmlessly in continuous mode
            if (last_word) begin
                state <= adc_types_pkg::idle;
            end
        end
    end

    always_comb begin
        rec_word.reserved = 1'b0;
        rec_word.sync     = sync_pipe[sync_delay-1];
        rec_word.pad      = '0;
        rec_word.sample   = sample;
    end

endmodule

// ==== source/adc_regs_pkg.sv ====
package adc_regs_pkg;

    typedef logic [3:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // zero wait state APB, no pready and no pslverr
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // register map
    localparam apb_addr_t ctrl_addr   = 4'h0;
    localparam apb_addr_t count_addr  = 4'h4;
    localparam apb_addr_t status_addr = 4'h8;
    localparam apb_addr_t data_addr   = 4'hC; // read pops one word

    // ctrl write bits, both self clearing
    localparam int soft_rst_bit = 0;
    localparam int start_bit    = 1;

    // status read bits
    localparam int busy_bit     = 0;
    localparam int empty_bit    = 1;
    localparam int full_bit     = 2;
    localparam int overflow_bit = 3;

endpackage

// ==== source/adc_rx_top.sv ====
`timescale 1ns/1ps

module adc_rx_top #(
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic                    ADC_CLK,
    input  logic                    RST,
    input  logic                    adc_in,
    input  logic                    adc_fco,
    input  logic                    adc_sync,
    input  adc_regs_pkg::apb_req_t  apb,
    output adc_regs_pkg::apb_data_t prdata
);

    adc_types_pkg::sample_t      sample;
    logic                        sample_valid;
    adc_types_pkg::record_word_t rec_word;
    logic                        rec_write;
    logic                        busy;
    logic                        soft_rst;
    logic                        start;
    adc_types_pkg::rec_count_t   rec_count;
    logic                        pop;
    adc_types_pkg::record_word_t head;
    logic                        empty;
    logic                        full;
    logic                        overflow;

    adc_deserializer deser0 (
        .ADC_CLK      (ADC_CLK),
        .RST          (RST),
        .adc_in       (adc_in),
        .adc_fco      (adc_fco),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    adc_record_ctrl rec0 (
        .ADC_CLK      (ADC_CLK),
        .RST          (RST),
        .soft_rst     (soft_rst),
        .start        (start),
        .rec_count    (rec_count),
        .sample       (sample),
        .sample_valid (sample_valid),
        .adc_sync     (adc_sync),
        .rec_word     (rec_word),
        .rec_write    (rec_write),
        .busy         (busy)
    );

    adc_sample_fifo #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) fifo0 (
        .ADC_CLK   (ADC_CLK),
        .RST       (RST),
        .soft_rst  (soft_rst),
        .rec_write (rec_write),
        .rec_word  (rec_word),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .full      (full),
        .overflow  (overflow)
    );

    adc_apb_regs regs0 (
        .ADC_CLK   (ADC_CLK),
        .RST       (RST),
        .apb       (apb),
        .prdata    (prdata),
        .soft_rst  (soft_rst),
        .start     (start),
        .rec_count (rec_count),
        .busy      (busy),
        .empty     (empty),
        .full      (full),
        .overflow  (overflow),
        .head      (head),
        .pop       (pop)
    );

endmodule

// ==== source/adc_sample_fifo.sv ====
`timescale 1ns/1ps

module adc_sample_fifo #(
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic                        ADC_CLK,
    input  logic                        RST,
    input  logic                        soft_rst,
    input  logic                        rec_write,
    input  adc_types_pkg::record_word_t rec_word,
    input  logic                        pop,
    output adc_types_pkg::record_word_t head,
    output logic                        empty,
    output logic                        full,
    output logic                        overflow
);

    localparam int depth = 1 << FIFO_DEPTH_LOG2;

    // extra msb tells full from empty
    typedef logic [FIFO_DEPTH_LOG2:0] ptr_t;

    adc_types_pkg::record_word_t mem [depth];
    ptr_t                        wr_ptr;
    ptr_t                        rd_ptr;
    logic                        do_write;
    logic                        do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2]) &&
                   (wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0]);

    assign do_write = rec_write && !full;
    assign do_pop   = pop && !empty;

    assign head = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]]; // show-ahead

    always_ff @(posedge ADC_CLK) begin
        if (do_write) begin
            mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= rec_word;
        end
    end

    always_ff @(posedge ADC_CLK) begin
        if (RST || soft_rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (rec_write && full) begin
                overflow <= 1'b1; // sticky, word is lost
            end
        end
    end

endmodule

// ==== source/adc_types_pkg.sv ====
package adc_types_pkg;

    // one conversion from the lane
    typedef logic [13:0] sample_t;

    // samples to keep after start, zero keeps everything
    typedef logic [23:0] rec_count_t;

    // word as it sits in the fifo and goes out on the bus
    typedef struct packed {
        logic       reserved;
        logic       sync;     // adc_sync level of the frame
        logic [15:0] pad;
        sample_t    sample;
    } record_word_t;

    typedef enum logic {
        idle,
        recording
    } rec_state_t;

endpackage

// ==== verification/adc_rx_checker.sv ====
`timescale 1ns/1ps

module adc_rx_checker (
    input  logic                    ADC_CLK,
    input  logic                    RST,
    input  adc_regs_pkg::apb_req_t  apb,
    input  adc_regs_pkg::apb_data_t prdata,
    output logic                    timed_out
);

    // about 60 frames plus bus traffic, times four
    localparam int timeout_cycles = 6000;

    logic [31:0] expected_q [$];
    logic [31:0] expected_word;
    int          cycle_count   = 0;
    int          check_count   = 0;
    int          error_count   = 0;
    int          test_count    = 0;
    int          errors_before = 0;

    // record word layout: reserved zero, sync, 16 pad zeros, sample
    function automatic logic [31:0] ref_word(input logic [13:0] smp, input logic sync);
        return {1'b0, sync, 16'h0000, smp};
    endfunction

    function automatic string reg_name(input logic [3:0] addr);
        case (addr)
            adc_regs_pkg::ctrl_addr:   return "ctrl";
            adc_regs_pkg::count_addr:  return "count";
            adc_regs_pkg::status_addr: return "status";
            adc_regs_pkg::data_addr:   return "data";
            default:                   return "unmapped";
        endcase
    endfunction

    task automatic expect_value(input logic [31:0] value);
        expected_q.push_back(value);
    endtask

    task automatic expect_word(input logic [13:0] smp, input logic sync);
        expected_q.push_back(ref_word(smp, sync));
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (expected_q.size() != 0) begin
            $display("%0d expected reads never happened in test %s", expected_q.size(), name);
            error_count++;
            expected_q.delete();
        end
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: FAIL, %0d errors", test_count, name,
                     error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    task automatic report_summary();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    endtask

    assign timed_out = (cycle_count >= timeout_cycles);

    always @(posedge ADC_CLK) begin
        if (cycle_count == timeout_cycles - 1) begin
            $display("run timed out after %0d cycles", timeout_cycles);
        end
        cycle_count <= cycle_count + 1;
    end

    // prdata is settled mid cycle of the access phase
    always @(negedge ADC_CLK) begin
        if (!RST && apb.psel && apb.penable && !apb.pwrite) begin
            if (expected_q.size() == 0) begin
                $display("read of %s register with no expected value queued",
                         reg_name(apb.paddr));
                error_count++;
            end else begin
                expected_word = expected_q.pop_front();
                check_count++;
                if (prdata !== expected_word) begin
                    $display("MISMATCH prdata at %s: expected 0x%08h actual 0x%08h",
                             reg_name(apb.paddr), expected_word, prdata);
                    error_count++;
                end
            end
        end
    end

endmodule

// ==== verification/adc_rx_tb.sv ====
`timescale 1ns/1ps

module adc_rx_tb;

    logic                    ADC_CLK = 1'b0;
    logic                    RST;
    logic                    adc_in;
    logic                    adc_fco;
    logic                    adc_sync;
    adc_regs_pkg::apb_req_t  apb;
    adc_regs_pkg::apb_data_t prdata;
    logic                    timed_out;
    logic [31:0]             rng_state = 32'he76006ed;
    adc_types_pkg::sample_t  frame_sample [20];
    logic                    frame_sync [20];

    adc_rx_top #(.FIFO_DEPTH_LOG2(4)) dut0 (
        .ADC_CLK  (ADC_CLK),
        .RST      (RST),
        .adc_in   (adc_in),
        .adc_fco  (adc_fco),
        .adc_sync (adc_sync),
        .apb      (apb),
        .prdata   (prdata)
    );

    adc_rx_checker chk0 (
        .ADC_CLK   (ADC_CLK),
        .RST       (RST),
        .apb       (apb),
        .prdata    (prdata),
        .timed_out (timed_out)
    );

    always #2 ADC_CLK = ~ADC_CLK;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] status_bits(input logic busy, input logic empty,
                                                input logic full, input logic ovf);
        return {28'h0, ovf, full, empty, busy};
    endfunction

    // setup phase, one access phase, then back to idle
    task automatic apb_cycle(input logic write, input adc_regs_pkg::apb_addr_t addr,
                             input adc_regs_pkg::apb_data_t data);
        @(posedge ADC_CLK);
        apb.psel    <= 1'b1;
        apb.penable <= 1'b0;
        apb.pwrite  <= write;
        apb.paddr   <= addr;
        apb.pwdata  <= data;
        @(posedge ADC_CLK);
        apb.penable <= 1'b1;
        @(posedge ADC_CLK);
        apb <= '0;
    endtask

    task automatic check_reg(input adc_regs_pkg::apb_addr_t addr, input logic [31:0] value);
        chk0.expect_value(value);
        apb_cycle(1'b0, addr, '0);
    endtask

    task automatic check_word(input adc_types_pkg::sample_t smp, input logic sync);
        chk0.expect_word(smp, sync);
        apb_cycle(1'b0, adc_regs_pkg::data_addr, '0);
    endtask

    // fco high for the first 7 bits, msb first
    task automatic send_frame(input adc_types_pkg::sample_t smp, input logic sync);
        for (int i = 0; i < 14; i++) begin
            @(posedge ADC_CLK);
            adc_in   <= smp[13 - i];
            adc_fco  <= (i < 7);
            adc_sync <= sync;
        end
    endtask

    task automatic stream_frames(input int n);
        for (int k = 0; k < n; k++) begin
            rng_state       = xorshift32(rng_state);
            frame_sample[k] = rng_state[13:0];
            frame_sync[k]   = rng_state[16];
            send_frame(frame_sample[k], frame_sync[k]);
        end
        repeat (4) begin // let the last sample reach the fifo
            @(posedge ADC_CLK);
            adc_in  <= 1'b0;
            adc_fco <= 1'b0;
        end
    endtask

    always @(posedge timed_out) begin
        $display("Checks failed");
        $finish;
    end

    initial begin
        RST      = 1'b1;
        adc_in   = 1'b0;
        adc_fco  = 1'b0;
        adc_sync = 1'b0;
        apb      = '0;
        repeat (3) @(posedge ADC_CLK);
        RST <= 1'b0;

        check_reg(adc_regs_pkg::count_addr, 32'd1);
        check_reg(adc_regs_pkg::status_addr, status_bits(0, 1, 0, 0));
        check_reg(adc_regs_pkg::data_addr, 32'h0);
        chk0.end_test("reset values");

        stream_frames(3); // nothing kept without start
        check_reg(adc_regs_pkg::status_addr, status_bits(0, 1, 0, 0));
        check_reg(adc_regs_pkg::data_addr, 32'h0);
        chk0.end_test("no start");

        apb_cycle(1'b1, adc_regs_pkg::count_addr, 32'd5);
        apb_cycle(1'b1, adc_regs_pkg::ctrl_addr, 32'h2);
        stream_frames(8);
        for (int n = 0; n < 5; n++) check_word(frame_sample[n], frame_sync[n]);
        check_reg(adc_regs_pkg::status_addr, status_bits(0, 1, 0, 0));
        chk0.end_test("fixed count");

        apb_cycle(1'b1, adc_regs_pkg::count_addr, 32'd0);
        apb_cycle(1'b1, adc_regs_pkg::ctrl_addr, 32'h2);
        stream_frames(6);
        for (int n = 0; n < 6; n++) check_word(frame_sample[n], frame_sync[n]);
        check_reg(adc_regs_pkg::status_addr, status_bits(1, 1, 0, 0));
        chk0.end_test("continuous");

        stream_frames(20); // four more than the fifo holds
        check_reg(adc_regs_pkg::status_addr, status_bits(1, 0, 1, 1));
        for (int n = 0; n < 16; n++) check_word(frame_sample[n], frame_sync[n]);
        chk0.end_test("overflow");

        apb_cycle(1'b1, adc_regs_pkg::count_addr, 32'h0012a5c3);
        stream_frames(2); // words left in the fifo
        check_reg(adc_regs_pkg::status_addr, status_bits(1, 0, 0, 1));
        apb_cycle(1'b1, adc_regs_pkg::ctrl_addr, 32'h1);
        check_reg(adc_regs_pkg::status_addr, status_bits(0, 1, 0, 0));
        check_reg(adc_regs_pkg::count_addr, 32'h0012a5c3);
        chk0.end_test("soft reset");

        chk0.report_summary();
        if (chk0.error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
